/* project.f */
verilog/fifo_cfg_pkg.sv
verilog/capture_pkg.sv
verilog/fifo_rd_if.sv
verilog/dual_port_ram.sv
verilog/sync_fifo.sv
verilog/queue_merger.sv
verilog/capture_merge_top.sv
tb/capture_merge_tb.sv

/* Bender.yml */
package:
  name: capture_merge

sources:
  # Packages first, then interface and modules bottom up
  - files:
      - verilog/fifo_cfg_pkg.sv
      - verilog/capture_pkg.sv
      - verilog/fifo_rd_if.sv
      - verilog/dual_port_ram.sv
      - verilog/sync_fifo.sv
      - verilog/queue_merger.sv
      - verilog/capture_merge_top.sv

  - target: test
    files:
      - tb/capture_merge_tb.sv

/* tb/capture_merge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the two-channel capture merger
module capture_merge_tb;

	localparam int DEPTH = 1 << fifo_cfg_pkg::DEFAULT_ADDR_W;

	// Rough length of each test in cycles
	localparam int T_RESET  = 20;
	localparam int T_SINGLE = 30;
	localparam int T_FULL   = 60;
	localparam int T_LQF    = 40;
	localparam int T_TIE    = 30;
	localparam int T_STREAM = 260;
	localparam int LIMIT    = 2 * (T_RESET + T_SINGLE + T_FULL + T_LQF + T_TIE + T_STREAM);

	logic        clk;
	logic        rst;
	logic [11:0] a_data;
	logic        a_wr;
	logic        a_full;
	logic [15:0] b_data;
	logic        b_wr;
	logic        b_full;
	logic        out_en;
	logic        out_valid;
	logic        out_chan;
	logic [15:0] out_data;

	// Expected words per channel and expected channel order
	capture_pkg::merged_t exp_a[$];
	capture_pkg::merged_t exp_b[$];
	capture_pkg::chan_t   exp_chan[$];

	int errors;
	int tests_run;
	int tests_failed;
	int cycle_count;

	capture_merge_top DUT (
		.clk       (clk),
		.rst       (rst),
		.a_data    (a_data),
		.a_wr      (a_wr),
		.a_full    (a_full),
		.b_data    (b_data),
		.b_wr      (b_wr),
		.b_full    (b_full),
		.out_en    (out_en),
		.out_valid (out_valid),
		.out_chan  (out_chan),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= LIMIT) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	task automatic check_word(input string name, input capture_pkg::merged_t exp,
			input capture_pkg::merged_t got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_chan(input string name, input capture_pkg::chan_t exp,
			input capture_pkg::chan_t got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %s got %s", $time, name, exp.name(),
				got.name());
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %b got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	// Match one output word against the model
	task automatic take_output();
		capture_pkg::chan_t got_chan;
		got_chan = capture_pkg::chan_t'(out_chan);
		if (exp_chan.size() > 0) begin
			check_chan("out_chan", exp_chan.pop_front(), got_chan);
		end
		if (got_chan == capture_pkg::CHAN_B) begin
			if (exp_b.size() == 0) begin
				$display("Word %h came out on channel B at %0t ns with none expected",
					out_data, $time);
				errors++;
			end else begin
				check_word("out_data", exp_b.pop_front(), out_data);
			end
		end else begin
			if (exp_a.size() == 0) begin
				$display("Word %h came out on channel A at %0t ns with none expected",
					out_data, $time);
				errors++;
			end else begin
				check_word("out_data", exp_a.pop_front(), out_data);
			end
		end
	endtask

	// Advance one clock and sample the outputs just after the edge
	task automatic tick();
		@(posedge clk);
		#1;
		if (out_valid === 1'b1) begin
			take_output();
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		a_wr = 1'b0;
		b_wr = 1'b0;
		out_en = 1'b0;
		exp_a.delete();
		exp_b.delete();
		exp_chan.delete();
		tick();
		tick();
		rst = 1'b0;
	endtask

	// Samples are zero-extended into the output word
	task automatic write_sample(input capture_pkg::sample_t s, input logic accept);
		a_wr = 1'b1;
		a_data = s;
		if (accept) begin
			exp_a.push_back({4'h0, s});
		end
	endtask

	// Events come out bit for bit
	task automatic write_event(input capture_pkg::event_t e, input logic accept);
		b_wr = 1'b1;
		b_data = e;
		if (accept) begin
			exp_b.push_back(capture_pkg::merged_t'(e));
		end
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while ((exp_a.size() + exp_b.size() + exp_chan.size()) > 0 && n < max_cycles) begin
			tick();
			n++;
		end
		if ((exp_a.size() + exp_b.size()) > 0) begin
			$display("%0d words on A and %0d on B never came out", exp_a.size(), exp_b.size());
			errors++;
		end
		if (exp_chan.size() > 0) begin
			$display("%0d expected channel slots were never used", exp_chan.size());
			errors++;
		end
		// Extra words would show up here
		repeat (4) tick();
	endtask

	// Expected channel order when the fuller queue goes first and ties alternate
	task automatic predict_order(input int la, input int lb, input capture_pkg::chan_t last);
		capture_pkg::chan_t pick;
		capture_pkg::chan_t prev;
		int na;
		int nb;
		na = la;
		nb = lb;
		prev = last;
		while (na + nb > 0) begin
			if (na == 0) begin
				pick = capture_pkg::CHAN_B;
			end else if (nb == 0) begin
				pick = capture_pkg::CHAN_A;
			end else if (nb > na) begin
				pick = capture_pkg::CHAN_B;
			end else if (na > nb) begin
				pick = capture_pkg::CHAN_A;
			end else if (prev == capture_pkg::CHAN_A) begin
				pick = capture_pkg::CHAN_B;
			end else begin
				pick = capture_pkg::CHAN_A;
			end
			exp_chan.push_back(pick);
			if (pick == capture_pkg::CHAN_B) begin
				nb--;
			end else begin
				na--;
			end
			prev = pick;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %-28s ok", name);
		end else begin
			tests_failed++;
			$display("Test %-28s FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		apply_reset();
		check_flag("a_full", 1'b0, a_full);
		check_flag("b_full", 1'b0, b_full);
		out_en = 1'b1;
		repeat (10) begin
			tick();
			check_flag("out_valid", 1'b0, out_valid);
		end
		out_en = 1'b0;
		report_test("reset state", e0);
	endtask

	task automatic test_channel_a();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		out_en = 1'b1;
		repeat (5) exp_chan.push_back(capture_pkg::CHAN_A);
		for (i = 0; i < 5; i++) begin
			r = $urandom;
			write_sample(r[11:0], 1'b1);
			tick();
			// First word shows up two edges after its strobe is driven
			if (i == 0) begin
				check_flag("out_valid", 1'b0, out_valid);
			end else if (i == 1) begin
				check_flag("out_valid", 1'b1, out_valid);
			end
		end
		a_wr = 1'b0;
		wait_drain(20);
		out_en = 1'b0;
		report_test("channel A order and format", e0);
	endtask

	task automatic test_full_drop();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		out_en = 1'b0;
		for (i = 0; i < 20; i++) begin
			check_flag("b_full", i >= DEPTH, b_full);
			r = $urandom;
			write_event(r[15:0], i < DEPTH);
			tick();
		end
		b_wr = 1'b0;
		check_flag("b_full", 1'b1, b_full);
		repeat (DEPTH) exp_chan.push_back(capture_pkg::CHAN_B);
		out_en = 1'b1;
		wait_drain(DEPTH + 10);
		check_flag("b_full", 1'b0, b_full);
		out_en = 1'b0;
		report_test("full and dropped writes", e0);
	endtask

	task automatic test_longest_first();
		int e0;
		int i;
		logic [31:0] r;
		e0 = errors;
		apply_reset();
		for (i = 0; i < 6; i++) begin
			r = $urandom;
			if (i < 3) begin
				write_sample(r[27:16], 1'b1);
			end else begin
				a_wr = 1'b0;
			end
			write_event(r[15:0], 1'b1);
			tick();
		end
		a_wr = 1'b0;
		b_wr = 1'b0;
		predict_order(3, 6, capture_pkg::CHAN_B);
		out_en = 1'b1;
		wait_drain(20);
		out_en = 1'b0;
		report_test("longest queue first", e0);
	endtask

	task automatic test_tie_after_reset();
		int e0;
		logic [31:0] r;
		e0 = errors;
		apply_reset();
		repeat (2) begin
			r = $urandom;
			write_sample(r[27:16], 1'b1);
			write_event(r[15:0], 1'b1);
			tick();
		end
		a_wr = 1'b0;
		b_wr = 1'b0;
		exp_chan.push_back(capture_pkg::CHAN_A);
		exp_chan.push_back(capture_pkg::CHAN_B);
		exp_chan.push_back(capture_pkg::CHAN_A);
		exp_chan.push_back(capture_pkg::CHAN_B);
		out_en = 1'b1;
		wait_drain(15);
		out_en = 1'b0;
		report_test("tie alternation after reset", e0);
	endtask

	task automatic test_streaming();
		int e0;
		logic [31:0] r;
		logic [31:0] r2;
		e0 = errors;
		repeat (200) begin
			r = $urandom;
			r2 = $urandom;
			out_en = r[0] | r[3];
			if (r[1]) begin
				write_sample(r[15:4], !a_full);
			end else begin
				a_wr = 1'b0;
			end
			if (r[2]) begin
				write_event(r2[15:0], !b_full);
			end else begin
				b_wr = 1'b0;
			end
			tick();
		end
		a_wr = 1'b0;
		b_wr = 1'b0;
		out_en = 1'b1;
		wait_drain(2 * DEPTH + 10);
		out_en = 1'b0;
		report_test("streaming mix", e0);
	endtask

	initial begin
		rst = 1'b1;
		a_data = '0;
		a_wr = 1'b0;
		b_data = '0;
		b_wr = 1'b0;
		out_en = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		void'($urandom(10));

		test_reset_state();
		test_channel_a();
		test_full_drop();
		test_longest_first();
		test_tie_after_reset();
		test_streaming();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/capture_merge_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Two capture FIFOs merged into a single tagged output stream
module capture_merge_top #(
	parameter int A_ADDR_W = fifo_cfg_pkg::DEFAULT_ADDR_W,
	parameter int B_ADDR_W = fifo_cfg_pkg::DEFAULT_ADDR_W
) (
	input  logic        clk,
	input  logic        rst,

	// Channel A samples
	input  logic [11:0] a_data,
	input  logic        a_wr,
	output logic        a_full,

	// Channel B events
	input  logic [15:0] b_data,
	input  logic        b_wr,
	output logic        b_full,

	// Merged stream
	input  logic        out_en,
	output logic        out_valid,
	output logic        out_chan,
	output logic [15:0] out_data
);

	fifo_rd_if #(
		.payload_t (capture_pkg::sample_t),
		.LVL_W     (fifo_cfg_pkg::level_w(A_ADDR_W))
	) a_rd ();

	fifo_rd_if #(
		.payload_t (capture_pkg::event_t),
		.LVL_W     (fifo_cfg_pkg::level_w(B_ADDR_W))
	) b_rd ();

	// Sample buffer
	sync_fifo #(
		.payload_t (capture_pkg::sample_t),
		.ADDR_W    (A_ADDR_W)
	) fifo_a (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (a_wr),
		.wr_data (a_data),
		.full    (a_full),
		.rd      (a_rd)
	);

	// Event buffer
	sync_fifo #(
		.payload_t (capture_pkg::event_t),
		.ADDR_W    (B_ADDR_W)
	) fifo_b (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (b_wr),
		.wr_data (b_data),
		.full    (b_full),
		.rd      (b_rd)
	);

	queue_merger merger (
		.clk       (clk),
		.rst       (rst),
		.out_en    (out_en),
		.a         (a_rd),
		.b         (b_rd),
		.out_valid (out_valid),
		.out_chan  (out_chan),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

/* verilog/queue_merger.sv */
`timescale 1ns/1ps
`default_nettype none

// Drains two FIFOs into one tagged stream, fuller queue first
module queue_merger (
	input  logic                clk,
	input  logic                rst,
	input  logic                out_en,

	// Channel A carries samples, channel B carries events
	fifo_rd_if.merger_side      a,
	fifo_rd_if.merger_side      b,

	output logic                out_valid,
	output capture_pkg::chan_t  out_chan,
	output capture_pkg::merged_t out_data
);

	logic               a_ready;
	logic               b_ready;
	logic               pick_b;
	logic               pop;
	logic               b_longer;
	logic               tie;
	capture_pkg::chan_t last_q;
	capture_pkg::chan_t sel_q;
	logic               valid_q;

	// A queue is a candidate only while the output is enabled
	assign a_ready = out_en & ~a.empty;
	assign b_ready = out_en & ~b.empty;

	assign b_longer = (b.level > a.level);
	assign tie      = (b.level == a.level);

	// Selection
	always_comb begin
		pick_b = 1'b0;
		if (b_ready) begin
			if (!a_ready) begin
				pick_b = 1'b1;
			end else if (b_longer) begin
				pick_b = 1'b1;
			end else if (tie) begin
				// Equal levels go to whoever waited last time
				pick_b = (last_q == capture_pkg::CHAN_A);
			end
		end
	end

	assign pop     = a_ready | b_ready;
	assign b.rd_en = pick_b;
	assign a.rd_en = a_ready & ~pick_b;

	// Round-robin memory, starts as if B was served so A wins the first tie
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_q <= capture_pkg::CHAN_B;
		end else if (pop) begin
			last_q <= pick_b ? capture_pkg::CHAN_B : capture_pkg::CHAN_A;
		end
	end

	// Output stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
			sel_q   <= capture_pkg::CHAN_A;
		end else begin
			valid_q <= pop;
			if (pop) begin
				sel_q <= pick_b ? capture_pkg::CHAN_B : capture_pkg::CHAN_A;
			end
		end
	end

	assign out_valid = valid_q;
	assign out_chan  = sel_q;

	// rd_data of the popped FIFO is fresh in this cycle
	always_comb begin
		if (sel_q == capture_pkg::CHAN_B) begin
			out_data = capture_pkg::merge_event(b.rd_data);
		end else begin
			out_data = capture_pkg::merge_sample(a.rd_data);
		end
	end

endmodule

`default_nettype wire

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Single-clock FIFO, occupancy based full and empty decode
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int ADDR_W = fifo_cfg_pkg::DEFAULT_ADDR_W
) (
	input  logic         clk,
	input  logic         rst,

	// Write side
	input  logic         wr_en,
	input  payload_t     wr_data,
	output logic         full,

	// Read side toward the merger
	fifo_rd_if.fifo_side rd
);

	localparam int DEPTH = 1 << ADDR_W;
	localparam int LVL_W = fifo_cfg_pkg::level_w(ADDR_W);

	logic [LVL_W-1:0]  occupancy;
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic              empty;
	logic              wr_int;
	logic              rd_int;

	// Flags straight from the count
	assign full  = (occupancy == LVL_W'(DEPTH));
	assign empty = (occupancy == '0);

	// A write into a full FIFO is dropped, even alongside a read
	assign wr_int = wr_en & ~full;
	// Reading an empty FIFO does nothing
	assign rd_int = rd.rd_en & ~empty;

	assign rd.empty = empty;
	assign rd.level = occupancy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			occupancy <= '0;
		end else begin
			case ({wr_int, rd_int})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	// Pointers wrap naturally at the depth
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_int) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (rd_int) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage, head item lands on rd_data one edge after the pop
	dual_port_ram #(
		.payload_t (payload_t),
		.ADDR_W    (ADDR_W)
	) mem (
		.clk     (clk),
		.wr_en   (wr_int),
		.wr_addr (wr_ptr),
		.wr_data (wr_data),
		.rd_en   (rd_int),
		.rd_addr (rd_ptr),
		.rd_data (rd.rd_data)
	);

endmodule

`default_nettype wire

/* verilog/dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// Simple two-port memory, one write port and one registered read port
module dual_port_ram #(
	parameter type payload_t = logic [7:0],
	parameter int ADDR_W = 4
) (
	input  logic              clk,
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  payload_t          wr_data,
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	output payload_t          rd_data
);

	localparam int DEPTH = 1 << ADDR_W;

	payload_t mem [0:DEPTH-1];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read port holds its last value between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/fifo_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Read side of one FIFO as seen by the merger
interface fifo_rd_if #(
	parameter type payload_t = logic [7:0],
	parameter int LVL_W = 5
);

	// Pop strobe, raised only toward a nonempty FIFO
	logic rd_en;
	// Head item, valid the cycle after a pop
	payload_t rd_data;
	logic empty;
	// Current occupancy
	logic [LVL_W-1:0] level;

	modport fifo_side (
		input  rd_en,
		output rd_data,
		output empty,
		output level
	);

	modport merger_side (
		output rd_en,
		input  rd_data,
		input  empty,
		input  level
	);

endinterface

`default_nettype wire

/* verilog/capture_pkg.sv */
`default_nettype none

// Payload records of the two capture channels and the merged stream
package capture_pkg;

	// Channel A sensor sample
	typedef logic [11:0] sample_t;

	// Channel B event record
	typedef struct packed {
		logic [3:0]  code;
		logic [11:0] stamp;
	} event_t;

	// Source tag carried next to every merged word
	typedef enum logic {
		CHAN_A = 1'b0,
		CHAN_B = 1'b1
	} chan_t;

	// Output word, wide enough for either record
	typedef logic [15:0] merged_t;

	// Samples are zero-extended into the output word
	function automatic merged_t merge_sample(input sample_t s);
		merged_t w;
		w = {4'b0000, s};
		return w;
	endfunction

	// Events pass through bit for bit
	function automatic merged_t merge_event(input event_t e);
		merged_t w;
		w = e;
		return w;
	endfunction

endpackage

`default_nettype wire

/* verilog/fifo_cfg_pkg.sv */
`default_nettype none

// Sizing shared by the FIFOs, their read interface and the top level
package fifo_cfg_pkg;

	// Address width of 4 gives a depth of 16 entries
	parameter int DEFAULT_ADDR_W = 4;

	// Occupancy counts 0 up to the full depth inclusive,
	// so it needs one bit more than the address
	function automatic int level_w(input int addr_w);
		int w;
		w = addr_w + 1;
		return w;
	endfunction

endpackage

`default_nettype wire
